// ==== src/isa_pkg.sv ====
package isa_pkg;

  // fetched instruction word width
  localparam int instr_width = 32;

  // major opcode, top six bits of every instruction
  typedef enum logic [5:0] {
    op_alu  = 6'd0,
    op_addi = 6'd1,
    op_lw   = 6'd2,
    op_sw   = 6'd3,
    op_beq  = 6'd4,
    op_out  = 6'd5,
    op_halt = 6'd6
  } opcode_t;

  // alu function select, carried in funct of the r format
  typedef enum logic [3:0] {
    fn_add = 4'd0,
    fn_sub = 4'd1,
    fn_and = 4'd2,
    fn_or  = 4'd3,
    fn_xor = 4'd4,
    // signed compare, result is 1 or 0
    fn_slt = 4'd5
  } alu_fn_t;

  // register number, sixteen registers
  typedef logic [3:0] reg_idx_t;

  // register-register format
  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [9:0] unused;
    alu_fn_t    funct;
  } r_fmt_t;

  // immediate format, also used by lw, sw, beq
  typedef struct packed {
    opcode_t            opcode;
    reg_idx_t           rd;
    reg_idx_t           rs1;
    logic [1:0]         unused;
    logic signed [15:0] imm;
  } i_fmt_t;

  // one word, two views; opcode and register fields line up
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

endpackage

// ==== src/mem_pkg.sv ====
package mem_pkg;

  // data path width, also the register width
  localparam int word_width = 32;

  // data memory depth, 12-bit word address
  localparam int dm_words_default = 4096;

  // instruction memory depth
  localparam int im_words_default = 256;

endpackage

// ==== src/dm_bus_if.sv ====
`timescale 1ns/1ps

interface dm_bus_if #(
  parameter int dm_words = mem_pkg::dm_words_default
);

  // word address width, wraps modulo depth
  localparam int addr_w = $clog2(dm_words);

  // global enable, nothing moves without it
  logic                            enable_dm;
  // registered read, wins over write
  logic                            enable_fetch;
  // write strobe
  logic                            enable_write;
  logic [addr_w-1:0]               address;
  logic [mem_pkg::word_width-1:0]  wdata;
  // holds last fetched word
  logic [mem_pkg::word_width-1:0]  rdata;

  // controller side
  modport ctrl (
    output enable_dm, enable_fetch, enable_write, address, wdata,
    input  rdata
  );

  // memory side
  modport mem (
    input  enable_dm, enable_fetch, enable_write, address, wdata,
    output rdata
  );

endinterface

// ==== src/data_mem.sv ====
`timescale 1ns/1ps

module data_mem #(
  parameter int dm_words = mem_pkg::dm_words_default
) (
  input logic     clk,
  input logic     rst,
  dm_bus_if.mem   bus
);

  // word store
  logic [mem_pkg::word_width-1:0] mem [dm_words];

  always_ff @(posedge clk) begin
    if (rst) begin
      // clear every word and the read register
      for (int i = 0; i < dm_words; i++) begin
        mem[i] <= '0;
      end
      bus.rdata <= '0;
    end else if (bus.enable_dm) begin
      if (bus.enable_fetch) begin
        // one cycle read, word held until next fetch
        bus.rdata <= mem[bus.address];
      end else if (bus.enable_write) begin
        // write only when no fetch this cycle
        mem[bus.address] <= bus.wdata;
      end
    end
  end

endmodule

// ==== src/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
  parameter int im_words = mem_pkg::im_words_default
) (
  input  logic                             clk,
  input  logic                             prog_we,
  input  logic [$clog2(im_words)-1:0]      prog_addr,
  input  logic [isa_pkg::instr_width-1:0]  prog_data,
  input  logic [$clog2(im_words)-1:0]      pc,
  output isa_pkg::instr_u                  instr
);

  // program store, survives core reset
  logic [isa_pkg::instr_width-1:0] mem [im_words];

  // load port from top level
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // async fetch read, one-state fetch
  assign instr = mem[pc];

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            rst,
  input  isa_pkg::reg_idx_t               rs1_idx,
  input  isa_pkg::reg_idx_t               rs2_idx,
  input  isa_pkg::reg_idx_t               rd_idx,
  input  logic                            we,
  input  logic [mem_pkg::word_width-1:0]  wd,
  output logic [mem_pkg::word_width-1:0]  rs1_val,
  output logic [mem_pkg::word_width-1:0]  rs2_val
);

  // sixteen general registers, r0 is ordinary
  logic [mem_pkg::word_width-1:0] regs [16];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd_idx] <= wd;
    end
  end

  // combinational read ports
  assign rs1_val = regs[rs1_idx];
  assign rs2_val = regs[rs2_idx];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_fn_t                fn,
  input  logic [mem_pkg::word_width-1:0]  a,
  input  logic [mem_pkg::word_width-1:0]  b,
  output logic [mem_pkg::word_width-1:0]  y,
  output logic                            eq
);

  always_comb begin
    case (fn)
      isa_pkg::fn_add: begin
        y = a + b;
      end
      isa_pkg::fn_sub: begin
        y = a - b;
      end
      isa_pkg::fn_and: begin
        y = a & b;
      end
      isa_pkg::fn_or: begin
        y = a | b;
      end
      isa_pkg::fn_xor: begin
        y = a ^ b;
      end
      isa_pkg::fn_slt: begin
        // signed compare, zero-extended flag
        y = {{(mem_pkg::word_width-1){1'b0}}, $signed(a) < $signed(b)};
      end
      default: begin
        // undefined function codes give zero
        y = '0;
      end
    endcase
  end

  // equality for beq, independent of fn
  assign eq = (a == b);

endmodule

// ==== src/core_ctrl.sv ====
`timescale 1ns/1ps

module core_ctrl #(
  parameter int dm_words = mem_pkg::dm_words_default,
  parameter int im_words = mem_pkg::im_words_default
) (
  input  logic                            clk,
  input  logic                            rst,
  input  isa_pkg::instr_u                 instr,
  output logic [$clog2(im_words)-1:0]     pc,
  output isa_pkg::reg_idx_t               rs1_idx,
  output isa_pkg::reg_idx_t               rs2_idx,
  output isa_pkg::reg_idx_t               rd_idx,
  output logic                            rf_we,
  output logic [mem_pkg::word_width-1:0]  rf_wd,
  input  logic [mem_pkg::word_width-1:0]  rs1_val,
  input  logic [mem_pkg::word_width-1:0]  rs2_val,
  output isa_pkg::alu_fn_t                alu_fn,
  output logic [mem_pkg::word_width-1:0]  alu_a,
  output logic [mem_pkg::word_width-1:0]  alu_b,
  input  logic [mem_pkg::word_width-1:0]  alu_y,
  input  logic                            alu_eq,
  dm_bus_if.ctrl                          dm,
  output logic                            out_valid,
  output logic [mem_pkg::word_width-1:0]  out_data,
  output logic                            halted
);

  localparam int im_aw = $clog2(im_words);
  localparam int dm_aw = $clog2(dm_words);

  // fsm states
  localparam logic [2:0] s_fetch  = 3'd0;
  localparam logic [2:0] s_decode = 3'd1;
  localparam logic [2:0] s_exec   = 3'd2;
  localparam logic [2:0] s_mem    = 3'd3;
  localparam logic [2:0] s_wb     = 3'd4;
  localparam logic [2:0] s_halt   = 3'd5;

  logic [2:0]                     state;
  logic [im_aw-1:0]               pc_q;
  // current instruction, one at a time
  isa_pkg::instr_u                ir;
  // alu result, kept for mem address and writeback
  logic [mem_pkg::word_width-1:0] alu_q;
  isa_pkg::opcode_t               opcode;
  logic [mem_pkg::word_width-1:0] imm_ext;

  // decode from both union views
  assign opcode  = ir.r.opcode;
  assign imm_ext = {{(mem_pkg::word_width-16){ir.i.imm[15]}}, ir.i.imm};

  assign pc      = pc_q;
  assign rs1_idx = ir.r.rs1;
  // sw stores rd, beq compares rs1 with rd
  assign rs2_idx = (opcode == isa_pkg::op_alu) ? ir.r.rs2 : ir.r.rd;
  assign rd_idx  = ir.r.rd;

  // alu operands; immediate forms add
  assign alu_fn = (opcode == isa_pkg::op_alu) ? ir.r.funct : isa_pkg::fn_add;
  assign alu_a  = rs1_val;
  assign alu_b  = (opcode == isa_pkg::op_alu || opcode == isa_pkg::op_beq) ? rs2_val : imm_ext;

  // writeback for alu, addi, lw only
  assign rf_we = (state == s_wb) && (opcode == isa_pkg::op_alu ||
                 opcode == isa_pkg::op_addi || opcode == isa_pkg::op_lw);
  assign rf_wd = (opcode == isa_pkg::op_lw) ? dm.rdata : alu_q;

  // data memory strobes, only in mem state
  assign dm.enable_dm    = (state == s_mem);
  assign dm.enable_fetch = (state == s_mem) && (opcode == isa_pkg::op_lw);
  assign dm.enable_write = (state == s_mem) && (opcode == isa_pkg::op_sw);
  // address wraps modulo depth
  assign dm.address      = alu_q[dm_aw-1:0];
  assign dm.wdata        = rs2_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= s_fetch;
      pc_q      <= '0;
      out_valid <= 1'b0;
      out_data  <= '0;
      halted    <= 1'b0;
    end else begin
      // pulse by default
      out_valid <= 1'b0;
      case (state)
        s_fetch: begin
          // pc now points at pc+1
          pc_q  <= pc_q + 1'b1;
          state <= s_decode;
        end
        s_decode: begin
          if (opcode == isa_pkg::op_halt) begin
            halted <= 1'b1;
            state  <= s_halt;
          end else begin
            state <= s_exec;
          end
        end
        s_exec: begin
          case (opcode)
            isa_pkg::op_beq: begin
              // taken target is pc+1+imm
              if (alu_eq) begin
                pc_q <= pc_q + im_aw'(ir.i.imm);
              end
              state <= s_fetch;
            end
            isa_pkg::op_lw, isa_pkg::op_sw: begin
              state <= s_mem;
            end
            isa_pkg::op_out: begin
              // visible during writeback
              out_valid <= 1'b1;
              out_data  <= rs1_val;
              state     <= s_wb;
            end
            isa_pkg::op_alu, isa_pkg::op_addi: begin
              state <= s_wb;
            end
            default: begin
              // unknown opcode skipped
              state <= s_fetch;
            end
          endcase
        end
        s_mem: begin
          // lw waits one cycle for rdata
          state <= (opcode == isa_pkg::op_lw) ? s_wb : s_fetch;
        end
        s_wb: begin
          state <= s_fetch;
        end
        default: begin
          // halted until reset
          state <= s_halt;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state == s_fetch) begin
      ir <= instr;
    end
    if (state == s_exec) begin
      alu_q <= alu_y;
    end
  end

endmodule

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
  parameter int dm_words = mem_pkg::dm_words_default,
  parameter int im_words = mem_pkg::im_words_default
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             prog_we,
  input  logic [$clog2(im_words)-1:0]      prog_addr,
  input  logic [isa_pkg::instr_width-1:0]  prog_data,
  output logic                             out_valid,
  output logic [mem_pkg::word_width-1:0]   out_data,
  output logic                             halted
);

  // fetch path
  logic [$clog2(im_words)-1:0]    pc;
  isa_pkg::instr_u                instr;
  // register file ports
  isa_pkg::reg_idx_t              rs1_idx;
  isa_pkg::reg_idx_t              rs2_idx;
  isa_pkg::reg_idx_t              rd_idx;
  logic                           rf_we;
  logic [mem_pkg::word_width-1:0] rf_wd;
  logic [mem_pkg::word_width-1:0] rs1_val;
  logic [mem_pkg::word_width-1:0] rs2_val;
  // alu ports
  isa_pkg::alu_fn_t               alu_fn;
  logic [mem_pkg::word_width-1:0] alu_a;
  logic [mem_pkg::word_width-1:0] alu_b;
  logic [mem_pkg::word_width-1:0] alu_y;
  logic                           alu_eq;

  // controller to data memory
  dm_bus_if #(.dm_words(dm_words)) dm_bus ();

  data_mem #(.dm_words(dm_words)) data_mem_i (
    .clk (clk),
    .rst (rst),
    .bus (dm_bus.mem)
  );

  inst_mem #(.im_words(im_words)) inst_mem_i (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .rst     (rst),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rd_idx  (rd_idx),
    .we      (rf_we),
    .wd      (rf_wd),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  alu alu_i (
    .fn (alu_fn),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y),
    .eq (alu_eq)
  );

  core_ctrl #(
    .dm_words (dm_words),
    .im_words (im_words)
  ) core_ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .pc        (pc),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .rd_idx    (rd_idx),
    .rf_we     (rf_we),
    .rf_wd     (rf_wd),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .alu_fn    (alu_fn),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_y     (alu_y),
    .alu_eq    (alu_eq),
    .dm        (dm_bus.ctrl),
    .out_valid (out_valid),
    .out_data  (out_data),
    .halted    (halted)
  );

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

  localparam int dm_words = 64;
  localparam int im_words = 256;
  localparam int im_aw = $clog2(im_words);

  logic             clk;
  logic             rst;
  logic             prog_we;
  logic [im_aw-1:0] prog_addr;
  logic [31:0]      prog_data;
  logic             out_valid;
  logic [31:0]      out_data;
  logic             halted;

  // program image loaded into the DUT and run by the model
  logic [31:0] prog [im_words];
  int          prog_len;
  // expected OUT values in order
  logic [31:0] exp_q [$];
  logic [31:0] expected_word;
  int          errors;
  int          checks;
  bit          hung;

  cpu_top #(.dm_words(dm_words), .im_words(im_words)) cpu_top_i (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // packs an r format word with 10 spare bits before funct
  function automatic logic [31:0] r_word(isa_pkg::alu_fn_t fn, int rd, int rs1, int rs2);
    r_word = {isa_pkg::op_alu, rd[3:0], rs1[3:0], rs2[3:0], 10'd0, fn};
  endfunction

  // packs an i format word with 2 spare bits before the signed imm
  function automatic logic [31:0] i_word(isa_pkg::opcode_t op, int rd, int rs1, int imm);
    i_word = {op, rd[3:0], rs1[3:0], 2'b00, imm[15:0]};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // reference alu from the isa rules
  function automatic logic [31:0] alu_ref(logic [3:0] fn, logic [31:0] a, logic [31:0] b);
    case (fn)
      isa_pkg::fn_add: alu_ref = a + b;
      isa_pkg::fn_sub: alu_ref = a - b;
      isa_pkg::fn_and: alu_ref = a & b;
      isa_pkg::fn_or:  alu_ref = a | b;
      isa_pkg::fn_xor: alu_ref = a ^ b;
      isa_pkg::fn_slt: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:         alu_ref = 32'd0;
    endcase
  endfunction

  // array model of the isa fills exp_q from a fresh reset state
  function automatic void predict_outputs();
    logic [31:0] regs [16];
    logic [31:0] dmem [dm_words];
    logic [31:0] w;
    logic [31:0] sum;
    int          pc;
    int          next_pc;
    int          imm;
    int          rd;
    int          rs1;
    int          rs2;
    int          steps;
    bit          done;
    exp_q.delete();
    for (int i = 0; i < 16; i++) regs[i] = 32'd0;
    for (int i = 0; i < dm_words; i++) dmem[i] = 32'd0;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 10000 && pc < prog_len) begin
      w = prog[pc];
      rd = int'(w[25:22]);
      rs1 = int'(w[21:18]);
      rs2 = int'(w[17:14]);
      imm = int'($signed(w[15:0]));
      // effective address wraps modulo depth
      sum = regs[rs1] + 32'(imm);
      next_pc = (pc + 1) % im_words;
      case (w[31:26])
        isa_pkg::op_alu:  regs[rd] = alu_ref(w[3:0], regs[rs1], regs[rs2]);
        isa_pkg::op_addi: regs[rd] = sum;
        isa_pkg::op_lw:   regs[rd] = dmem[sum % dm_words];
        isa_pkg::op_sw:   dmem[sum % dm_words] = regs[rd];
        isa_pkg::op_beq: begin
          if (regs[rs1] == regs[rd]) begin
            next_pc = ((pc + 1 + imm) % im_words + im_words) % im_words;
          end
        end
        isa_pkg::op_out:  exp_q.push_back(regs[rs1]);
        isa_pkg::op_halt: done = 1'b1;
        default: ;
      endcase
      pc = next_pc;
      steps++;
    end
    if (!done) begin
      $display("%0t: reference model did not reach HALT", $time);
      errors++;
    end
  endfunction

  // reset of at least 4 cycles with optional program load
  task automatic reset_core(input bit load);
    int cycles;
    cycles = 0;
    @(posedge clk);
    rst <= 1'b1;
    if (load) begin
      for (int i = 0; i < prog_len; i++) begin
        prog_we   <= 1'b1;
        prog_addr <= i[im_aw-1:0];
        prog_data <= prog[i];
        @(posedge clk);
        cycles++;
      end
    end
    prog_we <= 1'b0;
    while (cycles < 4) begin
      @(posedge clk);
      cycles++;
    end
    rst <= 1'b0;
  endtask

  task automatic wait_halted(input string name, input int limit);
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk);
      cyc++;
    end while (halted !== 1'b1 && cyc < limit);
    if (halted !== 1'b1) begin
      $display("%0t: %s did not reach HALT within %0d cycles", $time, name, limit);
      errors++;
      hung = 1'b1;
    end
  endtask

  task automatic run_case(input string name, input bit load, input int limit);
    if (!hung) begin
      predict_outputs();
      reset_core(load);
      wait_halted(name, limit);
      if (exp_q.size() != 0) begin
        $display("%0t: %s ended with %0d expected OUT values never reported",
                 $time, name, exp_q.size());
        errors++;
        exp_q.delete();
      end
    end
  endtask

  // compare every OUT pulse with the model
  always @(posedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("%0t: OUT pulse arrived with no expected value left", $time);
        errors++;
      end else begin
        expected_word = exp_q.pop_front();
        checks++;
        if (out_data !== expected_word) begin
          $display("Fail %0t out_data got %h expected %h", $time, out_data, expected_word);
          errors++;
        end
      end
    end
  end

  initial begin
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors = 0;
    checks = 0;
    hung = 1'b0;
    void'($urandom(95));

    // every alu function and signed slt both ways
    prog_len = 0;
    emit(i_word(isa_pkg::op_addi, 1, 0, 1234));
    emit(i_word(isa_pkg::op_addi, 2, 0, -5));
    emit(i_word(isa_pkg::op_addi, 3, 0, 3855));
    emit(r_word(isa_pkg::fn_add, 4, 1, 2));
    emit(i_word(isa_pkg::op_out, 0, 4, 0));
    emit(r_word(isa_pkg::fn_sub, 5, 1, 2));
    emit(i_word(isa_pkg::op_out, 0, 5, 0));
    emit(r_word(isa_pkg::fn_sub, 5, 2, 1));
    emit(i_word(isa_pkg::op_out, 0, 5, 0));
    emit(r_word(isa_pkg::fn_and, 6, 1, 3));
    emit(i_word(isa_pkg::op_out, 0, 6, 0));
    emit(r_word(isa_pkg::fn_or, 7, 1, 3));
    emit(i_word(isa_pkg::op_out, 0, 7, 0));
    emit(r_word(isa_pkg::fn_xor, 8, 1, 3));
    emit(i_word(isa_pkg::op_out, 0, 8, 0));
    emit(r_word(isa_pkg::fn_slt, 9, 2, 1));
    emit(i_word(isa_pkg::op_out, 0, 9, 0));
    emit(r_word(isa_pkg::fn_slt, 9, 1, 2));
    emit(i_word(isa_pkg::op_out, 0, 9, 0));
    emit(r_word(isa_pkg::fn_slt, 9, 1, 1));
    emit(i_word(isa_pkg::op_out, 0, 9, 0));
    emit(i_word(isa_pkg::op_halt, 0, 0, 0));
    run_case("alu functions", 1'b1, 4000);

    // addi at the immediate limits
    prog_len = 0;
    emit(i_word(isa_pkg::op_addi, 1, 0, 32767));
    emit(i_word(isa_pkg::op_out, 0, 1, 0));
    emit(i_word(isa_pkg::op_addi, 2, 0, -32768));
    emit(i_word(isa_pkg::op_out, 0, 2, 0));
    emit(i_word(isa_pkg::op_addi, 3, 1, -1));
    emit(i_word(isa_pkg::op_out, 0, 3, 0));
    emit(i_word(isa_pkg::op_addi, 4, 2, -1));
    emit(i_word(isa_pkg::op_out, 0, 4, 0));
    emit(i_word(isa_pkg::op_addi, 5, 4, 100));
    emit(i_word(isa_pkg::op_out, 0, 5, 0));
    emit(i_word(isa_pkg::op_halt, 0, 0, 0));
    run_case("addi immediates", 1'b1, 4000);

    // store/load round trip incl. last word, wrapped address and untouched word
    prog_len = 0;
    emit(i_word(isa_pkg::op_addi, 1, 0, 4369));
    emit(i_word(isa_pkg::op_addi, 2, 0, -2));
    emit(i_word(isa_pkg::op_addi, 3, 0, 8738));
    emit(i_word(isa_pkg::op_addi, 4, 0, 10));
    emit(i_word(isa_pkg::op_sw, 1, 0, 0));
    emit(i_word(isa_pkg::op_sw, 2, 0, 17));
    emit(i_word(isa_pkg::op_sw, 3, 0, dm_words - 1));
    emit(i_word(isa_pkg::op_sw, 3, 0, dm_words + 3));
    emit(i_word(isa_pkg::op_sw, 2, 4, 60));
    emit(i_word(isa_pkg::op_lw, 5, 0, 0));
    emit(i_word(isa_pkg::op_out, 0, 5, 0));
    emit(i_word(isa_pkg::op_lw, 6, 0, 17));
    emit(i_word(isa_pkg::op_out, 0, 6, 0));
    emit(i_word(isa_pkg::op_lw, 7, 0, dm_words - 1));
    emit(i_word(isa_pkg::op_out, 0, 7, 0));
    emit(i_word(isa_pkg::op_lw, 8, 0, 3));
    emit(i_word(isa_pkg::op_out, 0, 8, 0));
    emit(i_word(isa_pkg::op_lw, 9, 0, 6));
    emit(i_word(isa_pkg::op_out, 0, 9, 0));
    emit(i_word(isa_pkg::op_lw, 10, 0, 40));
    emit(i_word(isa_pkg::op_out, 0, 10, 0));
    emit(i_word(isa_pkg::op_halt, 0, 0, 0));
    run_case("load store", 1'b1, 4000);

    // countdown from 5 with exit beq taken at zero and back branch always taken
    prog_len = 0;
    emit(i_word(isa_pkg::op_addi, 1, 0, 5));
    emit(i_word(isa_pkg::op_addi, 3, 0, -1));
    emit(i_word(isa_pkg::op_out, 0, 1, 0));
    emit(r_word(isa_pkg::fn_add, 1, 1, 3));
    emit(i_word(isa_pkg::op_beq, 0, 1, 1));
    emit(i_word(isa_pkg::op_beq, 0, 0, -4));
    emit(i_word(isa_pkg::op_out, 0, 1, 0));
    emit(i_word(isa_pkg::op_halt, 0, 0, 0));
    run_case("countdown loop", 1'b1, 4000);

    // random straight-line programs ending in OUT of every register
    for (int n = 0; n < 20; n++) begin
      prog_len = 0;
      for (int r = 0; r < 16; r++) begin
        emit(i_word(isa_pkg::op_addi, r, 0, int'($urandom_range(0, 65535)) - 32768));
      end
      for (int k = 0; k < 24; k++) begin
        case ($urandom_range(0, 3))
          0: emit(r_word(isa_pkg::alu_fn_t'($urandom_range(0, 5)), int'($urandom_range(0, 15)),
                         int'($urandom_range(0, 15)), int'($urandom_range(0, 15))));
          1: emit(i_word(isa_pkg::op_addi, int'($urandom_range(0, 15)),
                         int'($urandom_range(0, 15)), int'($urandom_range(0, 65535)) - 32768));
          2: emit(i_word(isa_pkg::op_lw, int'($urandom_range(0, 15)),
                         int'($urandom_range(0, 15)), int'($urandom_range(0, 127))));
          default: emit(i_word(isa_pkg::op_sw, int'($urandom_range(0, 15)),
                               int'($urandom_range(0, 15)), int'($urandom_range(0, 127))));
        endcase
      end
      for (int r = 0; r < 16; r++) begin
        emit(i_word(isa_pkg::op_out, 0, r, 0));
      end
      emit(i_word(isa_pkg::op_halt, 0, 0, 0));
      run_case($sformatf("random program %0d", n), 1'b1, 4000);
    end

    // loads first then dirties r2 and word 5 so a rerun must see zeros again
    prog_len = 0;
    emit(i_word(isa_pkg::op_lw, 1, 0, 5));
    emit(i_word(isa_pkg::op_out, 0, 1, 0));
    emit(i_word(isa_pkg::op_out, 0, 2, 0));
    emit(i_word(isa_pkg::op_addi, 2, 0, 77));
    emit(i_word(isa_pkg::op_sw, 2, 0, 5));
    emit(i_word(isa_pkg::op_halt, 0, 0, 0));
    run_case("reset program first run", 1'b1, 4000);
    run_case("rerun after second reset", 1'b0, 4000);

    if (checks == 0) begin
      $display("no OUT value was ever checked");
      errors++;
    end
    $display("OUT values checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/isa_pkg.sv
src/mem_pkg.sv
src/dm_bus_if.sv
src/data_mem.sv
src/inst_mem.sv
src/reg_file.sv
src/alu.sv
src/core_ctrl.sv
src/cpu_top.sv
tests/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
